// File: sim.f
+incdir+tb
src/adpcma_cfg_pkg.sv
src/adpcma_dsp_pkg.sv
src/adpcma_addr_cnt.sv
src/adpcma_decoder.sv
src/adpcma_gain.sv
src/adpcma_acc.sv
src/adpcma_drv.sv
tb/tb_adpcma.sv

// File: Makefile
# Verilator build and run for the ADPCM-A driver testbench

VERILATOR ?= verilator
TOP       ?= tb_adpcma
FLIST     ?= sim.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/adpcma_model.svh
// adpcm-a reference model with rom image, superframe decode and mix, and typed compare tasks

logic [7:0]        rom_img [0:4095];    // random bytes filled at start
bit                m_on    [num_ch];
bit                m_nib   [num_ch];    // 1 = low nibble next
logic [23:0]       m_cur   [num_ch];    // {bank, addr}
int                m_x     [num_ch];    // predictor
int                m_idx   [num_ch];    // step index
logic [num_ch-1:0] m_flags = '0;

// every address bit reaches the byte
function automatic logic [7:0] rom_byte(input logic [23:0] a);
    return rom_img[a[11:0]] ^ a[19:12] ^ {a[23:20], a[23:20]};
endfunction

// one superframe applies the key command, decodes each live channel and mixes both sides
function automatic void model_step(input int sf, output logic signed [pcm_w-1:0] exp_l,
                                   output logic signed [pcm_w-1:0] exp_r);
    int         sum_l;
    int         sum_r;
    int         mag;
    int         d;
    int         a;
    int         v;
    int         lim;
    logic [7:0] cmd;
    logic [7:0] rb;
    logic [3:0] nib;
    sum_l = 0;
    sum_r = 0;
    if (key_sf.size() > 0 && key_sf[0] == sf) begin
        cmd = key_cmd_q.pop_front();
        void'(key_sf.pop_front());
        for (int k = 0; k < num_ch; k++) begin
            if (cmd[k] && cmd[7]) m_on[k] = 0;     // dump
            if (cmd[k] && !cmd[7]) begin            // key-on restarts from silence
                m_on[k]  = 1;
                m_nib[k] = 0;
                m_cur[k] = {start_m[k], 8'h00};
                m_x[k]   = 0;
                m_idx[k] = 0;
            end
        end
    end
    for (int k = 0; k < num_ch; k++) begin
        if (m_on[k]) begin
            rb  = rom_byte(m_cur[k]);
            nib = m_nib[k] ? rb[3:0] : rb[7:4];
            mag = int'(nib[2:0]);
            d   = ((2 * mag + 1) * int'(step_table[m_idx[k]])) / 8;
            m_x[k] = nib[3] ? m_x[k] - d : m_x[k] + d;
            m_x[k] = m_x[k] & 12'hfff;             // 12-bit wrap
            if (m_x[k] >= 2048) m_x[k] -= 4096;
            m_idx[k] += int'(index_adj[mag]);
            if (m_idx[k] < 0) m_idx[k] = 0;
            if (m_idx[k] > 48) m_idx[k] = 48;
            if (m_nib[k]) begin
                if (m_cur[k] == {end_m[k], 8'hff}) begin
                    m_on[k]    = 0;                 // last nibble still plays
                    m_flags[k] = 1'b1;
                end
                m_cur[k] = m_cur[k] + 24'd1;
            end
            m_nib[k] = !m_nib[k];
            a = int'(atl_m) + 31 - int'(lracl_m[k][4:0]);
            if (a > 63) a = 63;
            v = (m_x[k] * int'(gain_mant[a % 8])) >>> (7 + a / 8);
            if (lracl_m[k][7]) sum_l += v;
            if (lracl_m[k][6]) sum_r += v;
        end
    end
    lim = (1 << (pcm_w - 1)) - 1;
    if (sum_l > lim) sum_l = lim;
    if (sum_l < -lim - 1) sum_l = -lim - 1;
    if (sum_r > lim) sum_r = lim;
    if (sum_r < -lim - 1) sum_r = -lim - 1;
    exp_l = pcm_w'(sum_l);
    exp_r = pcm_w'(sum_r);
endfunction

task automatic check_pcm(input string what, input logic signed [pcm_w-1:0] got,
                         input logic signed [pcm_w-1:0] exp);
    if (got !== exp) begin
        report_fail($sformatf("[ERROR] %0d ns: %s is %0d, expected %0d",
                              $time, what, got, exp));
    end
endtask

task automatic check_flags(input logic [num_ch-1:0] got, input logic [num_ch-1:0] exp);
    if (got !== exp) begin
        report_fail($sformatf("[ERROR] %0d ns: flags are %b, expected %b",
                              $time, got, exp));
    end
endtask

// File: tb/tb_adpcma.sv
`timescale 1ns/100ps
// adpcm-a driver testbench for idle, one channel, six-channel mix, end flags, dump and clipping
module tb_adpcma
    import adpcma_cfg_pkg::*, adpcma_dsp_pkg::*;
();

    // six full-scale channels reach about 24.5k and clip only a narrower output
    localparam int pcm_w    = 14;
    localparam int t1_sf    = 4;        // idle
    localparam int t2_sf    = 40;       // single channel
    localparam int t3_sf    = 40;       // six channels before the dump
    localparam int t4_sf    = 480;      // rest of the 512-nibble regions
    localparam int t6_sf    = 100;      // loud mix
    localparam int idle_sf  = 3;
    localparam int total_sf = t1_sf + t2_sf + t3_sf + t4_sf + t6_sf + 4 * idle_sf + 14;
    localparam int limit    = total_sf * 36 + 200;

    logic                    cen6;
    logic                    rst_n;
    logic [att_w-1:0]        atl;
    logic [7:0]              lracl_in;
    logic [7:0]              aon_cmd;
    logic [7:0]              datain;
    logic [reg_addr_w-1:0]   addr_in;
    logic [2:0]              up_lracl;
    logic [2:0]              up_addr;
    logic                    up_start;
    logic                    up_end;
    logic                    up_aon;
    logic [num_ch-1:0]       clr_flags;
    logic [num_ch-1:0]       flags;
    logic [rom_addr_w-1:0]   addr;
    logic [bank_w-1:0]       bank;
    logic                    roe_n;
    logic                    sample_stb;
    logic signed [pcm_w-1:0] pcm_l;
    logic signed [pcm_w-1:0] pcm_r;

    // mirrors of the register writes, read by the model
    logic [15:0]             start_m [num_ch];
    logic [15:0]             end_m   [num_ch];
    logic [7:0]              lracl_m [num_ch];
    logic [att_w-1:0]        atl_m;
    int                      key_sf[$];         // superframe a key command lands in
    logic [7:0]              key_cmd_q[$];
    int                      sf_cnt;
    int                      cyc;
    int                      last_stb;
    int                      clip_hits;

    `include "adpcma_model.svh"

    adpcma_drv #(.pcm_w(pcm_w)) u_dut (
        .cen6(cen6), .rst_n(rst_n), .atl(atl), .lracl_in(lracl_in), .addr_in(addr_in),
        .up_lracl(up_lracl), .up_start(up_start), .up_end(up_end), .up_addr(up_addr),
        .aon_cmd(aon_cmd), .up_aon(up_aon), .datain(datain), .addr(addr), .bank(bank),
        .roe_n(roe_n), .clr_flags(clr_flags), .flags(flags), .pcm_l(pcm_l), .pcm_r(pcm_r),
        .sample_stb(sample_stb)
    );

    initial begin
        cen6 = 1'b0;
        forever #50 cen6 = ~cen6;
    end

    // rom answers mid-cycle, held through the latch slot
    always @(negedge cen6) begin
        if (!roe_n) datain <= rom_byte({bank, addr});
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on first error");
    endtask

    // returns at the falling edge of the n-th sample_stb
    task automatic wait_sf(input int n);
        repeat (n) begin
            @(negedge cen6);
            while (!sample_stb) @(negedge cen6);
        end
    endtask

    task automatic key_write(input logic [7:0] cmd);
        wait_sf(1);
        @(negedge cen6);                // first cycle of a superframe
        aon_cmd = cmd;
        up_aon  = 1'b1;
        key_sf.push_back(sf_cnt + 1);  // acts one superframe later
        key_cmd_q.push_back(cmd);
        @(negedge cen6);
        up_aon  = 1'b0;
    endtask

    // region of one 256-byte unit with start == end
    task automatic write_chan(input int ch, input logic [15:0] sa, input logic [7:0] lv);
        @(negedge cen6);
        up_addr  = 3'(ch);
        addr_in  = sa;
        up_start = 1'b1;
        @(negedge cen6);
        up_start = 1'b0;
        up_end   = 1'b1;
        @(negedge cen6);
        up_end   = 1'b0;
        up_lracl = 3'(ch);
        lracl_in = lv;
        @(negedge cen6);
        up_lracl = 3'd7;
        start_m[ch] = sa;
        end_m[ch]   = sa;
        lracl_m[ch] = lv;
    endtask

    task automatic set_atl(input logic [att_w-1:0] v);
        atl   = v;
        atl_m = v;
    endtask

    // compare at every sample strobe
    initial begin
        logic signed [pcm_w-1:0] el;
        logic signed [pcm_w-1:0] er;
        sf_cnt    = 0;
        clip_hits = 0;
        forever begin
            @(negedge cen6);
            if (rst_n && sample_stb) begin
                if (sf_cnt > 0 && cyc - last_stb != 36) begin
                    report_fail("sample_stb period is not 36 cycles");
                end
                last_stb = cyc;
                model_step(sf_cnt, el, er);
                check_pcm("pcm_l", pcm_l, el);
                check_pcm("pcm_r", pcm_r, er);
                check_flags(flags, m_flags);
                if (el == (1 << (pcm_w - 1)) - 1 || el == -(1 << (pcm_w - 1))) clip_hits++;
                sf_cnt++;
            end
        end
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge cen6);
            cyc++;
            if (cyc >= limit) report_fail("timeout: the run went past its cycle limit");
        end
    end

    initial begin
        rst_n     = 1'b0;
        atl       = '0;
        lracl_in  = '0;
        addr_in   = '0;
        up_lracl  = 3'd7;
        up_start  = 1'b0;
        up_end    = 1'b0;
        up_addr   = '0;
        aon_cmd   = '0;
        up_aon    = 1'b0;
        datain    = '0;
        clr_flags = '0;
        atl_m     = '0;
        for (int k = 0; k < num_ch; k++) begin
            start_m[k] = '0;
            end_m[k]   = '0;
            lracl_m[k] = '0;
        end
        void'($urandom(32'h8529));
        for (int i = 0; i < 4096; i++) rom_img[i] = 8'($urandom);
        repeat (5) @(negedge cen6);
        rst_n = 1'b1;
        // idle with no fetches
        repeat (t1_sf * 36) begin
            @(negedge cen6);
            if (!roe_n) report_fail("roe_n went low before any key-on");
        end
        // one channel on both sides
        write_chan(2, 16'h2340, {3'b110, 5'(16 + $urandom % 16)});
        set_atl('0);
        key_write(8'h04);
        wait_sf(t2_sf);
        key_write(8'h84);
        wait_sf(idle_sf);
        check_flags(flags, '0);
        // six channels with random pan and levels
        for (int k = 0; k < num_ch; k++) begin
            write_chan(k, {4'(k + 1), 12'($urandom)},
                       {2'($urandom), 1'b0, 5'(8 + $urandom % 24)});
        end
        set_atl(6'($urandom % 16));
        key_write(8'h3f);
        wait_sf(t3_sf);
        key_write(8'h90);               // dump ch4 only
        wait_sf(t4_sf);
        check_flags(flags, 6'b101111);  // all but the dumped one ended
        wait_sf(1);
        @(negedge cen6);
        clr_flags  = 6'b000010;
        m_flags[1] = 1'b0;
        @(negedge cen6);
        clr_flags  = '0;
        wait_sf(idle_sf);
        check_flags(flags, 6'b101101);
        // six identical loud channels
        for (int k = 0; k < num_ch; k++) write_chan(k, 16'h5a5a, 8'hdf);
        set_atl('0);
        key_write(8'h3f);
        wait_sf(t6_sf);
        key_write(8'hbf);
        wait_sf(idle_sf);
        if (clip_hits == 0) begin
            report_fail("the loud mix never reached the output clamp");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: src/adpcma_drv.sv
`timescale 1ns/100ps
// adpcm-a driver top: channel sequencer, key-on/dump scheduling, nibble latch and 6-ch mix
module adpcma_drv
    import adpcma_cfg_pkg::*, adpcma_dsp_pkg::*;
#(
    parameter int pcm_w = 16                        // output width
) (
    input  logic                    cen6,
    input  logic                    rst_n,
    // registers
    input  logic [att_w-1:0]        atl,            // total level
    input  logic [7:0]              lracl_in,       // pan + channel level
    input  logic [reg_addr_w-1:0]   addr_in,
    input  logic [2:0]              up_lracl,       // 6,7 = no write
    input  logic                    up_start,
    input  logic                    up_end,
    input  logic [2:0]              up_addr,
    input  logic [7:0]              aon_cmd,
    input  logic                    up_aon,
    // sample rom
    input  logic [7:0]              datain,
    output logic [rom_addr_w-1:0]   addr,
    output logic [bank_w-1:0]       bank,
    output logic                    roe_n,
    // end flags
    input  logic [num_ch-1:0]       clr_flags,
    output logic [num_ch-1:0]       flags,
    // mixed output
    output logic signed [pcm_w-1:0] pcm_l,
    output logic signed [pcm_w-1:0] pcm_r,
    output logic                    sample_stb
);

    logic [num_ch-1:0]       cur_ch;    // slot within frame
    logic [num_ch-1:0]       en_ch;     // channel owning the frame
    logic                    sf_end;
    logic [7:0]              aon_cpy;
    logic [7:0]              aon_now;
    logic [num_ch-1:0]       aon_sr;
    logic [num_ch-1:0]       aoff_sr;
    logic [3:0]              data;
    logic                    nib_sel;
    logic                    dec_on;
    logic                    dec_clr;
    logic signed [dec_w-1:0] pcm_dec;
    logic signed [mix_w-1:0] pcm_att;
    logic [1:0]              lr;        // {left, right}

    assign sf_end = cur_ch[num_ch-1] & en_ch[num_ch-1];    // last cycle of superframe

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            cur_ch <= num_ch'(1);
            en_ch  <= num_ch'(1);
        end else begin
            cur_ch <= {cur_ch[num_ch-2:0], cur_ch[num_ch-1]};
            if (cur_ch[num_ch-1]) begin
                en_ch <= {en_ch[num_ch-2:0], en_ch[num_ch-1]};  // next frame
            end
        end
    end

    // a write in the very last cycle still makes the next superframe
    assign aon_now = up_aon ? aon_cmd : aon_cpy;

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            aon_cpy <= '0;
            aon_sr  <= '0;
            aoff_sr <= '0;
        end else begin
            if (sf_end) begin
                aon_cpy <= '0;  // consumed
                aon_sr  <= aon_now[aon_dump_bit] ? '0 : aon_now[num_ch-1:0];
                aoff_sr <= aon_now[aon_dump_bit] ? aon_now[num_ch-1:0] : '0;
            end else begin
                if (up_aon) begin
                    aon_cpy <= aon_cmd;
                end
                if (cur_ch[num_ch-1]) begin
                    // bit 0 always belongs to the frame's channel
                    aon_sr  <= {1'b0, aon_sr[num_ch-1:1]};
                    aoff_sr <= {1'b0, aoff_sr[num_ch-1:1]};
                end
            end
        end
    end

    // rom answers one cycle after the address
    always_ff @(posedge cen6) begin
        if (cur_ch[slot_data]) begin
            data <= nib_sel ? datain[3:0] : datain[7:4];    // high nibble first
        end
    end

    adpcma_addr_cnt u_addr_cnt (
        .cen6      (cen6),
        .rst_n     (rst_n),
        .cur_ch    (cur_ch),
        .en_ch     (en_ch),
        .addr_in   (addr_in),
        .addr_ch   (up_addr),
        .up_start  (up_start),
        .up_end    (up_end),
        .aon       (aon_sr[0]),
        .aoff      (aoff_sr[0]),
        .clr_flags (clr_flags),
        .addr      (addr),
        .bank      (bank),
        .roe_n     (roe_n),
        .nib_sel   (nib_sel),
        .dec_on    (dec_on),
        .dec_clr   (dec_clr),
        .flags     (flags)
    );

    adpcma_decoder u_decoder (
        .cen6    (cen6),
        .rst_n   (rst_n),
        .cur_ch  (cur_ch),
        .en_ch   (en_ch),
        .data    (data),
        .dec_on  (dec_on),
        .dec_clr (dec_clr),
        .pcm     (pcm_dec)
    );

    adpcma_gain u_gain (
        .cen6    (cen6),
        .rst_n   (rst_n),
        .cur_ch  (cur_ch),
        .en_ch   (en_ch),
        .atl     (atl),
        .lracl   (lracl_in),
        .up_ch   (up_lracl),
        .pcm_in  (pcm_dec),
        .lr      (lr),
        .pcm_att (pcm_att)
    );

    adpcma_acc #(.pcm_w(pcm_w)) u_acc_l (
        .cen6       (cen6),
        .rst_n      (rst_n),
        .cur_ch     (cur_ch),
        .en_ch      (en_ch),
        .en_sum     (lr[1]),
        .pcm_in     (pcm_att),
        .pcm_out    (pcm_l),
        .sample_stb (sample_stb)
    );

    adpcma_acc #(.pcm_w(pcm_w)) u_acc_r (
        .cen6       (cen6),
        .rst_n      (rst_n),
        .cur_ch     (cur_ch),
        .en_ch      (en_ch),
        .en_sum     (lr[0]),
        .pcm_in     (pcm_att),
        .pcm_out    (pcm_r),
        .sample_stb ()                  // same timing as left
    );

    a_seq_onehot: assert property (@(posedge cen6) disable iff (!rst_n)
        $onehot(cur_ch) && $onehot(en_ch));

    a_on_off_excl: assert property (@(posedge cen6) disable iff (!rst_n)
        (aon_sr & aoff_sr) == '0);

endmodule

// File: src/adpcma_acc.sv
`timescale 1ns/100ps
// adpcm-a side accumulator: sums enabled channels over a superframe, saturates, dumps
module adpcma_acc
    import adpcma_cfg_pkg::*, adpcma_dsp_pkg::*;
#(
    parameter int pcm_w = 16
) (
    input  logic                    cen6,
    input  logic                    rst_n,
    input  logic [num_ch-1:0]       cur_ch,
    input  logic [num_ch-1:0]       en_ch,
    input  logic                    en_sum,     // this side enabled for the channel
    input  logic signed [mix_w-1:0] pcm_in,
    output logic signed [pcm_w-1:0] pcm_out,
    output logic                    sample_stb
);

    // three extra bits hold six full-scale channels
    localparam int sum_w = ((pcm_w > mix_w) ? pcm_w : mix_w) + 3;
    localparam logic signed [sum_w-1:0] pos_max =
        {{(sum_w-pcm_w+1){1'b0}}, {(pcm_w-1){1'b1}}};
    localparam logic signed [sum_w-1:0] neg_min =
        {{(sum_w-pcm_w+1){1'b1}}, {(pcm_w-1){1'b0}}};

    logic signed [sum_w-1:0] sum;
    logic signed [sum_w-1:0] add_in;
    logic signed [sum_w-1:0] sum_nxt;
    logic                    dump;

    assign dump    = cur_ch[slot_acc] & en_ch[num_ch-1];   // last channel's add
    assign add_in  = en_sum ? sum_w'(pcm_in) : '0;
    assign sum_nxt = sum + add_in;

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            sum        <= '0;
            pcm_out    <= '0;
            sample_stb <= 1'b0;
        end else begin
            sample_stb <= dump;     // lands in slot 5 of frame 5
            if (dump) begin
                sum <= '0;
                if (sum_nxt > pos_max) begin
                    pcm_out <= pos_max[pcm_w-1:0];
                end else if (sum_nxt < neg_min) begin
                    pcm_out <= neg_min[pcm_w-1:0];
                end else begin
                    pcm_out <= sum_nxt[pcm_w-1:0];
                end
            end else if (cur_ch[slot_acc]) begin
                sum <= sum_nxt;
            end
        end
    end

    a_out_with_stb: assert property (@(posedge cen6) disable iff (!rst_n)
        $changed(pcm_out) |-> sample_stb);

endmodule

// File: src/adpcma_gain.sv
`timescale 1ns/100ps
// adpcm-a gain: per-channel level and pan bytes, attenuation of the decoded sample
module adpcma_gain
    import adpcma_cfg_pkg::*, adpcma_dsp_pkg::*;
(
    input  logic                    cen6,
    input  logic                    rst_n,
    input  logic [num_ch-1:0]       cur_ch,
    input  logic [num_ch-1:0]       en_ch,
    input  logic [att_w-1:0]        atl,        // total level
    input  logic [7:0]              lracl,      // {L, R, -, level}
    input  logic [2:0]              up_ch,      // 6,7 = no write
    input  logic signed [dec_w-1:0] pcm_in,
    output logic [1:0]              lr,
    output logic signed [mix_w-1:0] pcm_att
);

    logic [7:0]              lracl_r [num_ch];
    logic [2:0]              ch;
    logic [level_w-1:0]      level;
    logic [att_w:0]          att_sum;           // one spare bit for saturation
    logic [att_w-1:0]        att;
    logic [3:0]              shift;
    logic signed [dec_w+8:0] prod;

    assign ch    = ch_idx(en_ch);
    assign level = lracl_r[ch][level_w-1:0];

    // ~level is 31 - level
    assign att_sum = {1'b0, atl} + {{(att_w+1-level_w){1'b0}}, ~level};
    assign att     = att_sum[att_w] ? '1 : att_sum[att_w-1:0];
    assign shift   = 4'd7 + {1'b0, att[att_w-1:3]};      // whole 6 dB steps
    assign prod    = pcm_in * $signed({1'b0, gain_mant[att[2:0]]});

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                lracl_r[i] <= '0;
            end
            lr      <= '0;
            pcm_att <= '0;
        end else begin
            if (int'(up_ch) < num_ch) begin
                lracl_r[up_ch] <= lracl;
            end
            if (cur_ch[slot_gain]) begin
                lr      <= {lracl_r[ch][lr_hi], lracl_r[ch][lr_lo]};
                pcm_att <= mix_w'(prod >>> shift);
            end
        end
    end

endmodule

// File: src/adpcma_decoder.sv
`timescale 1ns/100ps
// adpcm-a decoder: per-channel predictor and step index, one nibble per channel per superframe
module adpcma_decoder
    import adpcma_cfg_pkg::*, adpcma_dsp_pkg::*;
(
    input  logic                    cen6,
    input  logic                    rst_n,
    input  logic [num_ch-1:0]       cur_ch,
    input  logic [num_ch-1:0]       en_ch,
    input  logic [3:0]              data,       // sign + 3-bit magnitude
    input  logic                    dec_on,
    input  logic                    dec_clr,    // first nibble after key-on
    output logic signed [dec_w-1:0] pcm
);

    logic signed [dec_w-1:0] x_r   [num_ch];    // predictor
    logic [5:0]              idx_r [num_ch];    // step index 0..48
    logic [2:0]              ch;
    logic signed [dec_w-1:0] x_cur;
    logic signed [dec_w-1:0] x_nxt;
    logic [5:0]              idx_cur;
    logic [5:0]              idx_nxt;
    logic signed [7:0]       idx_sum;
    logic [15:0]             step;
    logic [19:0]             diff_full;
    logic [dec_w-1:0]        diff;

    assign ch      = ch_idx(en_ch);
    assign x_cur   = dec_clr ? '0 : x_r[ch];    // restart from silence
    assign idx_cur = dec_clr ? '0 : idx_r[ch];
    assign step    = step_table[idx_cur];

    // (2m+1) * step / 8
    assign diff_full = 20'(step) * 20'({data[2:0], 1'b1});
    assign diff      = dec_w'(diff_full >> 3);
    assign x_nxt     = data[3] ? x_cur - diff : x_cur + diff;   // wraps at 12 bits

    assign idx_sum = $signed({2'b00, idx_cur}) + index_adj[data[2:0]];

    always_comb begin
        if (idx_sum < 0) begin
            idx_nxt = '0;
        end else if (idx_sum > idx_max) begin
            idx_nxt = 6'(idx_max);
        end else begin
            idx_nxt = idx_sum[5:0];
        end
    end

    always_ff @(posedge cen6) begin
        if (cur_ch[slot_dec] && dec_on) begin
            x_r[ch]   <= x_nxt;
            idx_r[ch] <= idx_nxt;
        end
    end

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            pcm <= '0;
        end else if (cur_ch[slot_dec]) begin
            pcm <= dec_on ? x_nxt : '0;     // silent while off
        end
    end

endmodule

// File: src/adpcma_addr_cnt.sv
`timescale 1ns/100ps
// adpcm-a address counter: per-channel start/end/current address, rom fetch and end flags
module adpcma_addr_cnt
    import adpcma_cfg_pkg::*;
(
    input  logic                    cen6,
    input  logic                    rst_n,
    input  logic [num_ch-1:0]       cur_ch,
    input  logic [num_ch-1:0]       en_ch,
    input  logic [reg_addr_w-1:0]   addr_in,
    input  logic [2:0]              addr_ch,
    input  logic                    up_start,
    input  logic                    up_end,
    input  logic                    aon,        // key-on, held for the frame
    input  logic                    aoff,       // dump, held for the frame
    input  logic [num_ch-1:0]       clr_flags,
    output logic [rom_addr_w-1:0]   addr,
    output logic [bank_w-1:0]       bank,
    output logic                    roe_n,
    output logic                    nib_sel,    // valid in slot_data
    output logic                    dec_on,
    output logic                    dec_clr,
    output logic [num_ch-1:0]       flags
);

    localparam int full_w = bank_w + rom_addr_w;
    localparam int low_w  = full_w - reg_addr_w;    // byte bits below a 256-byte unit

    logic [reg_addr_w-1:0] start_r [num_ch];
    logic [reg_addr_w-1:0] end_r   [num_ch];
    logic [full_w-1:0]     cur_r   [num_ch];        // byte address incl. bank
    logic [num_ch-1:0]     nib_r;                   // 1 = low nibble next
    logic [num_ch-1:0]     on_r;
    logic [2:0]            ch;
    logic                  on_now;
    logic                  nib_now;
    logic                  at_end;
    logic [full_w-1:0]     cur_now;
    logic [num_ch-1:0]     flag_set;

    assign ch = ch_idx(en_ch);

    // key-on acts in the same slot_addr so the first fetch is not lost
    assign on_now  = aon | (on_r[ch] & ~aoff);
    assign cur_now = aon ? {start_r[ch], {low_w{1'b0}}} : cur_r[ch];
    assign nib_now = aon ? 1'b0 : nib_r[ch];
    assign at_end  = on_now & nib_now & (cur_now == {end_r[ch], {low_w{1'b1}}});

    assign {bank, addr} = cur_now;
    assign roe_n        = ~(cur_ch[slot_addr] & on_now);
    assign flag_set     = (cur_ch[slot_addr] && at_end) ? (num_ch'(1) << ch) : '0;

    always_ff @(posedge cen6) begin
        if (up_start && int'(addr_ch) < num_ch) begin
            start_r[addr_ch] <= addr_in;
        end
        if (up_end && int'(addr_ch) < num_ch) begin
            end_r[addr_ch] <= addr_in;
        end
        if (cur_ch[slot_addr] && on_now) begin
            cur_r[ch] <= nib_now ? cur_now + full_w'(1) : cur_now;  // step after low nibble
        end
    end

    always_ff @(posedge cen6 or negedge rst_n) begin
        if (!rst_n) begin
            nib_r   <= '0;
            on_r    <= '0;
            nib_sel <= 1'b0;
            dec_on  <= 1'b0;
            dec_clr <= 1'b0;
            flags   <= '0;
        end else begin
            flags <= (flags & ~clr_flags) | flag_set;   // a new end wins over a clear
            if (cur_ch[slot_addr]) begin
                on_r[ch]  <= on_now & ~at_end;          // past end: stop
                nib_r[ch] <= on_now & ~nib_now;
                nib_sel   <= nib_now;
                dec_on    <= on_now;                    // held for the rest of the frame
                dec_clr   <= aon;
            end
        end
    end

    // one fetch per frame, single-cycle enable
    a_roe_slot: assert property (@(posedge cen6) disable iff (!rst_n)
        !roe_n |-> cur_ch[slot_addr] ##1 roe_n);

endmodule

// File: src/adpcma_dsp_pkg.sv
// adpcm-a dsp package: decoder step and index tables, gain mantissas and sample widths
package adpcma_dsp_pkg;

    localparam int dec_w   = 12;    // decoded sample
    localparam int mix_w   = 16;    // attenuated sample fed to the mixers
    localparam int att_w   = 6;     // total + channel attenuation, 0.75 dB units
    localparam int idx_max = 48;    // last step_table entry

    // adpcm-a step sizes, roughly 1.1x per index
    localparam logic [15:0] step_table [0:48] = '{
        16'd16,   16'd17,   16'd19,   16'd21,   16'd23,   16'd25,   16'd28,
        16'd31,   16'd34,   16'd37,   16'd41,   16'd45,   16'd50,   16'd55,
        16'd60,   16'd66,   16'd73,   16'd80,   16'd88,   16'd97,   16'd107,
        16'd118,  16'd130,  16'd143,  16'd157,  16'd173,  16'd190,  16'd209,
        16'd230,  16'd253,  16'd279,  16'd307,  16'd337,  16'd371,  16'd408,
        16'd449,  16'd494,  16'd544,  16'd598,  16'd658,  16'd724,  16'd796,
        16'd876,  16'd963,  16'd1060, 16'd1166, 16'd1282, 16'd1411, 16'd1552
    };

    // step index move, by nibble magnitude
    localparam logic signed [3:0] index_adj [0:7] = '{
        -4'sd1, -4'sd1, -4'sd1, -4'sd1,
         4'sd2,  4'sd5,  4'sd7,  4'sd9
    };

    // one octave of gain in 0.75 dB steps, 255 = unity before the >>7
    localparam logic [7:0] gain_mant [0:7] = '{
        8'd255, 8'd234, 8'd215, 8'd197,
        8'd181, 8'd166, 8'd152, 8'd139
    };

endpackage

// File: src/adpcma_cfg_pkg.sv
// adpcm-a config package: channel count, pipeline slots, command fields and address widths
package adpcma_cfg_pkg;

    localparam int num_ch       = 6;    // channels, also cycles per frame
    // position of each pipeline step inside a six-cycle frame
    localparam int slot_addr    = 0;    // rom address out, roe_n low
    localparam int slot_data    = 1;    // nibble latch
    localparam int slot_dec     = 2;    // predictor update
    localparam int slot_gain    = 3;    // attenuation
    localparam int slot_acc     = 4;    // side accumulators
    localparam int aon_dump_bit = 7;    // key cmd: 0 key-on, 1 dump
    localparam int lr_hi        = 7;    // level byte, left enable
    localparam int lr_lo        = 6;    // level byte, right enable
    localparam int level_w      = 5;    // per-channel level field
    localparam int rom_addr_w   = 20;
    localparam int bank_w       = 4;
    localparam int reg_addr_w   = 16;   // start/end regs in 256-byte units

    // one-hot channel vector to channel number
    function automatic logic [2:0] ch_idx(input logic [num_ch-1:0] oh);
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < num_ch; i++) begin
            if (oh[i]) idx = 3'(i);
        end
        return idx;
    endfunction

endpackage
